// ==== verilog.f ====
+incdir+bench
rtl/memPkg.sv
rtl/loadAlign.sv
rtl/storeMerge.sv
rtl/lsuPort.sv
rtl/axiLiteSlave.sv
rtl/memArbiter.sv
rtl/dataRam.sv
rtl/memSubsystem.sv
bench/memSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# compile the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module memSubsystemTb \
    -f verilog.f \
    -o memSubsystemSim
./obj_dir/memSubsystemSim

// ==== bench/memTbTasks.svh ====
// reset, core and host drivers, byte reference model, lcg and value check

    logic [7:0] refMem [1024];  // byte model of the ram, indexed by byte address

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fillPattern(input logic [7:0] w);
        return {w, ~w, w ^ 8'h5a, w[3:0], w[7:4]};  // each byte follows the full address
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic void applyStrobe(input logic [7:0] wordAddr, input logic [3:0] strb,
                                        input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) refMem[{wordAddr, 2'(i)}] = data[i*8 +: 8];  // little endian lane i
        end
    endfunction

    function automatic void applyStore(input logic [3:0] op, input logic [9:0] addr,
                                       input logic [31:0] data);
        case (op)
            memPkg::opStoreByte: refMem[addr] = data[7:0];
            memPkg::opStoreHalf: begin
                refMem[{addr[9:2], addr[1], 1'b0}] = data[7:0];  // addr bit 0 ignored
                refMem[{addr[9:2], addr[1], 1'b1}] = data[15:8];
            end
            memPkg::opStoreWord: applyStrobe(addr[9:2], 4'hf, data);
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] refWord(input logic [7:0] wordAddr);
        return {refMem[{wordAddr, 2'd3}], refMem[{wordAddr, 2'd2}],
                refMem[{wordAddr, 2'd1}], refMem[{wordAddr, 2'd0}]};
    endfunction

    function automatic logic [31:0] expectLoad(input logic [3:0] op, input logic [9:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = refMem[addr];
        h = {refMem[{addr[9:2], addr[1], 1'b1}], refMem[{addr[9:2], addr[1], 1'b0}]};
        case (op)
            memPkg::opLoadHalfU: return {16'h0, h};
            memPkg::opLoadHalf:  return {{16{h[15]}}, h};
            memPkg::opLoadByteU: return {24'h0, b};
            memPkg::opLoadByte:  return {{24{b[7]}}, b};
            default:             return refWord(addr[9:2]);  // word and spare codes
        endcase
    endfunction

    task automatic applyReset();
        repeat (2) @(posedge clk);  // rst high since time zero
        rst <= 1'b0;
    endtask

    // one core request held until lsuDone with the result checked against the model
    task automatic coreAccess(input logic [3:0] op, input logic [9:0] addr,
                              input logic [31:0] data, input logic [31:0] regIn,
                              input logic memToReg);
        @(posedge clk);
        lsuReq       <= 1'b1;
        lsuOp        <= op;
        lsuAddr      <= addr;
        lsuStoreData <= data;
        lsuRegIn     <= regIn;
        lsuMemToReg  <= memToReg;
        @(negedge clk);
        while (!lsuDone) begin
            @(negedge clk);
        end
        if (!memToReg) begin
            checkValue("lsuResult", lsuResult, regIn);  // bypass
        end else if (op[3]) begin
            applyStore(op, addr, data);
        end else begin
            checkValue("lsuResult", lsuResult, expectLoad(op, addr));
        end
        @(posedge clk);
        lsuReq <= 1'b0;
    endtask

    task automatic hostWrite(input logic [7:0] wordAddr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(posedge clk);
        awaddr  <= {wordAddr, 2'b00};
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        checkValue("wready", {31'h0, wready}, 32'h1);  // W taken in the AW cycle
        @(posedge clk);
        awvalid <= 1'b0;  // AW and W taken together
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        checkValue("bresp", {30'h0, bresp}, 32'h0);
        applyStrobe(wordAddr, strb, data);
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic hostRead(input logic [7:0] wordAddr);
        @(posedge clk);
        araddr  <= {wordAddr, 2'b00};
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        checkValue("rdata", rdata, refWord(wordAddr));
        checkValue("rresp", {30'h0, rresp}, 32'h0);
        @(posedge clk);
        rready <= 1'b0;
    endtask

// ==== bench/memSubsystemTb.sv ====
// testbench top with clock, reset, DUT instance, cycle timeout and directed tests
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int          timeoutCycles = 3000;     // directed tests take about 600 cycles
    localparam logic [31:0] lcgSeed       = 32'h43b7;

    logic        clk, rst;
    // core memory stage
    logic        lsuReq, lsuMemToReg, lsuDone;
    logic [3:0]  lsuOp;
    logic [9:0]  lsuAddr;
    logic [31:0] lsuStoreData, lsuRegIn, lsuResult;
    // host AXI4-Lite
    logic [9:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    int          cycleCount = 0;

    `include "memTbTasks.svh"

    memSubsystem memSubsystem_inst (.*);

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout, the tests did not finish within %0d cycles", timeoutCycles);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // known contents in words 0..31 where every test stays
    task automatic fillMemory();
        for (int w = 0; w < 32; w++) begin
            hostWrite(8'(w), fillPattern(8'(w)), 4'hf);
        end
    endtask

    task automatic wordAccessTest();
        logic [9:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = {8'(3 * i + 1), 2'b00};
            coreAccess(memPkg::opStoreWord, addr, 32'hc0de_0000 | 32'(i * 257), 32'h0, 1'b1);
            coreAccess(memPkg::opLoadWord, addr, 32'h0, 32'h0, 1'b1);
        end
    endtask

    task automatic subwordLoadTest();
        logic [3:0] op;
        // msb set in lanes 3,2 of word 2 and lanes 1,0 of word 3
        coreAccess(memPkg::opStoreWord, {8'd2, 2'b00}, 32'hf08a_7c35, 32'h0, 1'b1);
        coreAccess(memPkg::opStoreWord, {8'd3, 2'b00}, 32'h6b19_e4a2, 32'h0, 1'b1);
        for (int w = 2; w < 4; w++) begin
            for (int k = 0; k < 4; k++) begin
                op = memPkg::opLoadHalfU + 4'(k);  // halfU, half, byteU, byte
                for (int s = 0; s < 4; s++) begin
                    coreAccess(op, {8'(w), 2'(s)}, 32'h0, 32'h0, 1'b1);
                end
            end
        end
        // spare codes read the whole word
        coreAccess(4'b0001, {8'd2, 2'b00}, 32'h0, 32'h0, 1'b1);
        coreAccess(4'b0110, {8'd3, 2'b00}, 32'h0, 32'h0, 1'b1);
        coreAccess(4'b0111, {8'd2, 2'b00}, 32'h0, 32'h0, 1'b1);
    endtask

    task automatic subwordStoreTest();
        logic [31:0] data;
        for (int s = 0; s < 4; s++) begin
            data = 32'hdead_be00 | 32'(s + 16);  // upper bits must not reach the ram
            coreAccess(memPkg::opStoreByte, {8'd5, 2'(s)}, data, 32'h0, 1'b1);
            hostRead(8'd5);
        end
        for (int s = 0; s < 4; s++) begin
            data = 32'hfeed_0000 | 32'(s * 4369);
            coreAccess(memPkg::opStoreHalf, {8'd6, 2'(s)}, data, 32'h0, 1'b1);
            hostRead(8'd6);
        end
    endtask

    task automatic axiStrobeTest();
        logic [31:0] data;
        for (int st = 1; st < 16; st++) begin
            data = {4{8'(st * 17)}} ^ 32'h5a3c_96e1;
            hostWrite(8'd8, data, 4'(st));
            coreAccess(memPkg::opLoadWord, {8'd8, 2'b00}, 32'h0, 32'h0, 1'b1);
            coreAccess(memPkg::opLoadByteU, {8'd8, 2'(st)}, 32'h0, 32'h0, 1'b1);
        end
        // core store seen from the host
        coreAccess(memPkg::opStoreWord, {8'd9, 2'b00}, 32'h3141_5926, 32'h0, 1'b1);
        hostRead(8'd9);
    endtask

    task automatic bypassTest();
        logic [31:0] s;
        logic [3:0]  op;
        s = lcgNext(lcgSeed);
        for (int i = 0; i < 4; i++) begin
            s  = lcgNext(s);
            op = i[0] ? memPkg::opStoreWord : memPkg::opLoadByte;  // both skip the ram
            coreAccess(op, {8'(2 + i), 2'b00}, ~s, s, 1'b0);
            hostRead(8'(2 + i));  // word untouched
        end
    endtask

    // core keeps to words 0..15, so the two ports never share a word
    task automatic randomCoreTraffic(input int count);
        logic [31:0] s;
        logic [3:0]  op;
        logic [9:0]  addr;
        s = lcgSeed;
        for (int i = 0; i < count; i++) begin
            s = lcgNext(s);
            case (s[18:16])
                3'd0:    op = memPkg::opLoadWord;
                3'd1:    op = memPkg::opLoadHalfU;
                3'd2:    op = memPkg::opLoadHalf;
                3'd3:    op = memPkg::opLoadByteU;
                3'd4:    op = memPkg::opLoadByte;
                3'd5:    op = memPkg::opStoreByte;
                3'd6:    op = memPkg::opStoreHalf;
                default: op = memPkg::opStoreWord;
            endcase
            addr = {4'b0000, s[25:20]};
            if (op == memPkg::opLoadWord || op == memPkg::opStoreWord) begin
                addr[1:0] = 2'b00;  // word ops aligned
            end
            coreAccess(op, addr, lcgNext(s), s, 1'b1);
        end
    endtask

    task automatic randomHostTraffic(input int count);
        logic [31:0] s;
        logic [7:0]  wa;
        s = ~lcgSeed;
        for (int i = 0; i < count; i++) begin
            s  = lcgNext(s);
            wa = {4'b0001, s[23:20]};  // words 16..31
            if (s[27]) begin
                hostWrite(wa, lcgNext(s), s[31:28]);
            end else begin
                hostRead(wa);
            end
        end
    endtask

    task automatic contentionTest();
        fork
            randomCoreTraffic(16);
            randomHostTraffic(16);
        join
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        lsuReq       = 1'b0;
        lsuOp        = 4'h0;
        lsuAddr      = 10'h0;
        lsuStoreData = 32'h0;
        lsuRegIn     = 32'h0;
        lsuMemToReg  = 1'b0;
        awaddr       = 10'h0;
        awvalid      = 1'b0;
        wdata        = 32'h0;
        wstrb        = 4'h0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = 10'h0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        applyReset();
        fillMemory();
        wordAccessTest();
        subwordLoadTest();
        subwordStoreTest();
        axiStrobeTest();
        bypassTest();
        contentionTest();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== rtl/memSubsystem.sv ====
// core port, AXI4-Lite host port, arbiter and data ram
`timescale 1ns/1ps

module memSubsystem (
    input  logic                          clk,
    input  logic                          rst,
    // core memory stage
    input  logic                          lsuReq,
    input  logic [3:0]                    lsuOp,
    input  logic [memPkg::byteAddrW-1:0]  lsuAddr,
    input  logic [memPkg::wordSize-1:0]   lsuStoreData,
    input  logic [memPkg::wordSize-1:0]   lsuRegIn,
    input  logic                          lsuMemToReg,
    output logic                          lsuDone,
    output logic [memPkg::wordSize-1:0]   lsuResult,
    // host AXI4-Lite
    input  logic [memPkg::byteAddrW-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [memPkg::wordSize-1:0]   wdata,
    input  logic [memPkg::laneCount-1:0]  wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [memPkg::byteAddrW-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [memPkg::wordSize-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    logic                            coreReq, coreWrite, coreGrant, coreRvalid;
    logic [memPkg::ramDepthLog2-1:0] coreWordAddr;
    logic [memPkg::wordSize-1:0]     coreWdata, coreRdata;
    logic [memPkg::laneCount-1:0]    coreBe;
    logic                            hostReq, hostWrite, hostGrant, hostRvalid;
    logic [memPkg::ramDepthLog2-1:0] hostWordAddr;
    logic [memPkg::wordSize-1:0]     hostWdata, hostRdata;
    logic [memPkg::laneCount-1:0]    hostBe;
    logic                            ramEn;
    logic [memPkg::laneCount-1:0]    ramWe;
    logic [memPkg::ramDepthLog2-1:0] ramAddr;
    logic [memPkg::wordSize-1:0]     ramWdata, ramRdata;

    lsuPort lsuPort_inst (.*);  // core requester

    axiLiteSlave axiLiteSlave_inst (.*);  // host requester

    memArbiter memArbiter_inst (.*);

    dataRam dataRam_inst (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

// ==== rtl/dataRam.sv ====
// single-port word ram with byte write enables and registered read
`timescale 1ns/1ps

module dataRam (
    input  logic                            clk,
    input  logic                            ramEn,
    input  logic [memPkg::laneCount-1:0]    ramWe,     // one bit per byte lane
    input  logic [memPkg::ramDepthLog2-1:0] ramAddr,
    input  logic [memPkg::wordSize-1:0]     ramWdata,
    output logic [memPkg::wordSize-1:0]     ramRdata
);

    logic [memPkg::wordSize-1:0] mem [memPkg::ramDepth];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (ramEn) begin
            for (int lane = 0; lane < memPkg::laneCount; lane++) begin
                if (ramWe[lane]) begin
                    mem[ramAddr][lane*memPkg::byteSize +: memPkg::byteSize] <=
                        ramWdata[lane*memPkg::byteSize +: memPkg::byteSize];
                end
            end
        end
    end

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (ramEn) begin
            ramRdata <= mem[ramAddr];
        end
    end

endmodule

// ==== rtl/memArbiter.sv ====
// two-way round-robin onto the single ram port with read-data return
`timescale 1ns/1ps

module memArbiter (
    input  logic                            clk,
    input  logic                            rst,
    // core requester
    input  logic                            coreReq,
    input  logic                            coreWrite,
    input  logic [memPkg::ramDepthLog2-1:0] coreWordAddr,
    input  logic [memPkg::wordSize-1:0]     coreWdata,
    input  logic [memPkg::laneCount-1:0]    coreBe,
    output logic                            coreGrant,
    output logic                            coreRvalid,
    output logic [memPkg::wordSize-1:0]     coreRdata,
    // host requester
    input  logic                            hostReq,
    input  logic                            hostWrite,
    input  logic [memPkg::ramDepthLog2-1:0] hostWordAddr,
    input  logic [memPkg::wordSize-1:0]     hostWdata,
    input  logic [memPkg::laneCount-1:0]    hostBe,
    output logic                            hostGrant,
    output logic                            hostRvalid,
    output logic [memPkg::wordSize-1:0]     hostRdata,
    // ram port
    output logic                            ramEn,
    output logic [memPkg::laneCount-1:0]    ramWe,
    output logic [memPkg::ramDepthLog2-1:0] ramAddr,
    output logic [memPkg::wordSize-1:0]     ramWdata,
    input  logic [memPkg::wordSize-1:0]     ramRdata
);

    logic lastHost;  // host took the last grant so core wins the next tie

    assign coreGrant = coreReq && (!hostReq || lastHost);
    assign hostGrant = hostReq && !coreGrant;

    // ram driven by the winner
    assign ramEn    = coreGrant || hostGrant;
    assign ramAddr  = coreGrant ? coreWordAddr : hostWordAddr;
    assign ramWdata = coreGrant ? coreWdata : hostWdata;
    assign ramWe    = coreGrant ? (coreWrite ? coreBe : '0) :
                      hostGrant ? (hostWrite ? hostBe : '0) : '0;

    // read data goes to both and rvalid marks the owner
    assign coreRdata = ramRdata;
    assign hostRdata = ramRdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastHost   <= 1'b1;
            coreRvalid <= 1'b0;
            hostRvalid <= 1'b0;
        end else begin
            if (ramEn) lastHost <= hostGrant;
            coreRvalid <= coreGrant && !coreWrite;  // ram data lands next cycle
            hostRvalid <= hostGrant && !hostWrite;
        end
    end

endmodule

// ==== rtl/axiLiteSlave.sv ====
// AXI4-Lite host port turned into word requests for the arbiter
`timescale 1ns/1ps

module axiLiteSlave (
    input  logic                            clk,
    input  logic                            rst,
    // write address / data / response
    input  logic [memPkg::byteAddrW-1:0]    awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [memPkg::wordSize-1:0]     wdata,
    input  logic [memPkg::laneCount-1:0]    wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    // read address / data
    input  logic [memPkg::byteAddrW-1:0]    araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [memPkg::wordSize-1:0]     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    // arbiter side
    output logic                            hostReq,
    output logic                            hostWrite,
    output logic [memPkg::ramDepthLog2-1:0] hostWordAddr,
    output logic [memPkg::wordSize-1:0]     hostWdata,
    output logic [memPkg::laneCount-1:0]    hostBe,
    input  logic                            hostGrant,
    input  logic                            hostRvalid,
    input  logic [memPkg::wordSize-1:0]     hostRdata
);

    logic                        pending;   // request waiting for grant
    logic                        isRead;
    logic                        idle;
    logic [memPkg::wordSize-1:0] rdataHold; // read word kept while rready is low

    // one transaction at a time until its response is taken
    assign idle    = !pending && !bvalid && !rvalid;
    assign arready = idle && arvalid;
    assign awready = idle && awvalid && wvalid && !arvalid;  // read wins a tie
    assign wready  = awready;

    assign hostReq   = pending;
    assign hostWrite = !isRead;

    assign bresp = memPkg::respOkay;
    assign rresp = memPkg::respOkay;
    assign rdata = hostRvalid ? hostRdata : rdataHold;  // first beat straight from ram

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            isRead  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arready) begin
                pending <= 1'b1;
                isRead  <= 1'b1;
            end else if (awready) begin
                pending <= 1'b1;
                isRead  <= 1'b0;
            end else if (hostGrant) begin
                pending <= 1'b0;
                rvalid  <= isRead;
                bvalid  <= !isRead;
            end
            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (arready) hostWordAddr <= araddr[memPkg::byteAddrW-1:2];
        if (awready) begin
            hostWordAddr <= awaddr[memPkg::byteAddrW-1:2];
            hostWdata    <= wdata;
            hostBe       <= wstrb;
        end
        if (hostRvalid) rdataHold <= hostRdata;
    end

endmodule

// ==== rtl/lsuPort.sv ====
// core memory-stage request sequencer with store merge and load align
`timescale 1ns/1ps

module lsuPort (
    input  logic                           clk,
    input  logic                           rst,
    // core side
    input  logic                           lsuReq,
    input  logic [3:0]                     lsuOp,
    input  logic [memPkg::byteAddrW-1:0]   lsuAddr,
    input  logic [memPkg::wordSize-1:0]    lsuStoreData,
    input  logic [memPkg::wordSize-1:0]    lsuRegIn,
    input  logic                           lsuMemToReg,
    output logic                           lsuDone,
    output logic [memPkg::wordSize-1:0]    lsuResult,
    // arbiter side
    output logic                           coreReq,
    output logic                           coreWrite,
    output logic [memPkg::ramDepthLog2-1:0] coreWordAddr,
    output logic [memPkg::wordSize-1:0]    coreWdata,
    output logic [memPkg::laneCount-1:0]   coreBe,
    input  logic                           coreGrant,
    input  logic                           coreRvalid,
    input  logic [memPkg::wordSize-1:0]    coreRdata
);

    logic [1:0] state;

    // only memory ops reach the arbiter
    assign coreReq = (state == memPkg::lsuWaitGrant) ||
                     (state == memPkg::lsuIdle && lsuReq && lsuMemToReg);
    assign coreWrite    = lsuOp[3];
    assign coreWordAddr = lsuAddr[memPkg::byteAddrW-1:2];

    // stores finish on the cycle after grant and loads when read data returns
    assign lsuDone = (state == memPkg::lsuFinish) &&
                     (!lsuMemToReg || lsuOp[3] || coreRvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::lsuIdle;
        end else begin
            case (state)
                memPkg::lsuIdle: begin
                    if (lsuReq) begin
                        if (!lsuMemToReg || coreGrant) begin
                            state <= memPkg::lsuFinish;  // bypass or granted at once
                        end else begin
                            state <= memPkg::lsuWaitGrant;
                        end
                    end
                end
                memPkg::lsuWaitGrant: if (coreGrant) state <= memPkg::lsuFinish;
                memPkg::lsuFinish:    if (lsuDone) state <= memPkg::lsuIdle;
                default:              state <= memPkg::lsuIdle;
            endcase
        end
    end

    storeMerge storeMerge_inst (
        .op        (lsuOp),
        .byteSel   (lsuAddr[1:0]),
        .storeData (lsuStoreData),
        .be        (coreBe),
        .wdata     (coreWdata)
    );

    loadAlign loadAlign_inst (
        .memIn    (coreRdata),
        .regIn    (lsuRegIn),
        .op       (lsuOp),
        .byteSel  (lsuAddr[1:0]),
        .memToReg (lsuMemToReg),
        .out      (lsuResult)
    );

endmodule

// ==== rtl/storeMerge.sv ====
// store byte enables and lane-replicated write data
`timescale 1ns/1ps

module storeMerge (
    input  logic [3:0]                   op,
    input  logic [1:0]                   byteSel,    // low address bits
    input  logic [memPkg::wordSize-1:0]  storeData,  // register value with data in low bits
    output logic [memPkg::laneCount-1:0] be,
    output logic [memPkg::wordSize-1:0]  wdata
);

    memPkg::memWord wd;

    always_comb begin
        be       = '0;         // loads write nothing
        wd.whole = storeData;  // word store passes straight through
        case (op)
            memPkg::opStoreByte: begin
                // low byte on every lane with one lane enabled
                wd.bytes    = {memPkg::laneCount{storeData[memPkg::byteSize-1:0]}};
                be[byteSel] = 1'b1;
            end
            memPkg::opStoreHalf: begin
                wd.halves = {2{storeData[memPkg::halfSize-1:0]}};
                if (byteSel[1]) begin
                    be = 4'b1100;  // upper half
                end else begin
                    be = 4'b0011;
                end
            end
            memPkg::opStoreWord: begin
                be = 4'b1111;
            end
            default: begin
                be = '0;
            end
        endcase
    end

    assign wdata = wd.whole;

endmodule

// ==== rtl/loadAlign.sv ====
// byte/halfword select, zero/sign extension and writeback select
`timescale 1ns/1ps

module loadAlign (
    input  logic [memPkg::wordSize-1:0] memIn,     // word read from ram
    input  logic [memPkg::wordSize-1:0] regIn,     // alu result for non-load writeback
    input  logic [3:0]                  op,
    input  logic [1:0]                  byteSel,   // low address bits
    input  logic                        memToReg,
    output logic [memPkg::wordSize-1:0] out
);

    memPkg::memWord              memW;
    logic [memPkg::halfSize-1:0] halfVal;
    logic [memPkg::byteSize-1:0] byteVal;
    logic [memPkg::wordSize-1:0] extVal;

    assign memW.whole = memIn;

    // lane pick
    assign halfVal = memW.halves[byteSel[1]];  // bit 0 ignored for halves
    assign byteVal = memW.bytes[byteSel];

    always_comb begin
        case (op)
            memPkg::opLoadHalfU: begin
                extVal = {{(memPkg::wordSize - memPkg::halfSize){1'b0}}, halfVal};
            end
            memPkg::opLoadHalf: begin
                // replicate the half's msb
                extVal = {{(memPkg::wordSize - memPkg::halfSize){halfVal[memPkg::halfSize-1]}},
                          halfVal};
            end
            memPkg::opLoadByteU: begin
                extVal = {{(memPkg::wordSize - memPkg::byteSize){1'b0}}, byteVal};
            end
            memPkg::opLoadByte: begin
                extVal = {{(memPkg::wordSize - memPkg::byteSize){byteVal[memPkg::byteSize-1]}},
                          byteVal};
            end
            default: extVal = memW.whole;  // word load, 0001/0110/0111 and stores
        endcase
    end

    // writeback select
    assign out = memToReg ? extVal : regIn;

endmodule

// ==== rtl/memPkg.sv ====
// widths, ram depth, operation codes, fsm codes, bus responses and the memWord union
package memPkg;

    // basic widths
    localparam int wordSize  = 32;
    localparam int halfSize  = 16;
    localparam int byteSize  = 8;
    localparam int laneCount = wordSize / byteSize;  // byte lanes per word

    // ram geometry
    localparam int ramDepthLog2 = 8;                 // word address bits
    localparam int ramDepth     = 1 << ramDepthLog2;
    localparam int byteAddrW    = ramDepthLog2 + 2;  // byte address bits

    // memory op codes with the top bit marking a store
    localparam logic [3:0] opLoadWord  = 4'b0000;
    localparam logic [3:0] opLoadHalfU = 4'b0010;
    localparam logic [3:0] opLoadHalf  = 4'b0011;
    localparam logic [3:0] opLoadByteU = 4'b0100;
    localparam logic [3:0] opLoadByte  = 4'b0101;
    localparam logic [3:0] opStoreByte = 4'b1000;
    localparam logic [3:0] opStoreHalf = 4'b1001;
    localparam logic [3:0] opStoreWord = 4'b1010;

    // lsu sequencer states
    localparam logic [1:0] lsuIdle      = 2'd0;
    localparam logic [1:0] lsuWaitGrant = 2'd1;
    localparam logic [1:0] lsuFinish    = 2'd2;

    // the only axi response ever returned
    localparam logic [1:0] respOkay = 2'b00;

    // one memory word with lane 0 as the low byte (little endian)
    typedef union packed {
        logic [wordSize-1:0]                  whole;
        logic [laneCount-1:0][byteSize-1:0]   bytes;   // bytes[byteSel]
        logic [1:0][halfSize-1:0]             halves;  // halves[byteSel[1]]
    } memWord;

endpackage
